/* vlog.f */
+incdir+source
source/chipRamPkg.sv
source/agnusCapture.sv
source/refreshTimer.sv
source/cycleSequencer.sv
source/sdramCmdOut.sv
source/chipRamTop.sv
tb/sdramMonitor.sv
tb/chipRamTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the chip RAM controller simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module chipRamTb \
    -o chipRamSim

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/chipRamSim

/* tb/chipRamTb.sv */
// Chip RAM controller testbench
// Directed init, CPU, DMA, refresh and priority tests on the SDRAM pins

`include "chipRam_cfg.svh"

module chipRamTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        CAS_AGNUS = 1'b0;
    logic        nRESET;
    logic        nRamSpace;
    logic [20:1] cpuAddr;
    logic        cpuRnW;
    logic [1:0]  tt;
    logic        nRas0;
    logic        nRas1;
    logic        nCasL;
    logic        nCasU;
    logic        nAwe;
    logic [9:0]  dra;
    logic        nCs;
    logic        nRas;
    logic        nCas;
    logic        nWe;
    logic        clkEn;
    logic [10:0] cma;
    logic        ramTa;
    logic        nDbEn;
    logic        dbDir;
    logic        dmaCycle;
    logic        burstCycle;
    logic        wordSel;
    logic        rowOpen;
    logic [10:0] openRow;
    logic [10:0] lastCol;
    logic [15:0] refreshCount;
    logic        protocolError;
    logic [31:0] lcgState = 32'h3ab9;
    logic [3:0]  pinCmd;

    assign pinCmd = {nCs, nRas, nCas, nWe};

    chipRamTop dut_i (.*);

    sdramMonitor monitor_i (
        .CAS_AGNUS(CAS_AGNUS), .nRESET(nRESET), .nCs(nCs), .nRas(nRas), .nCas(nCas),
        .nWe(nWe), .clkEn(clkEn), .cma(cma), .rowOpen(rowOpen), .openRow(openRow),
        .lastCol(lastCol), .refreshCount(refreshCount), .protocolError(protocolError)
    );

    always #20 CAS_AGNUS = ~CAS_AGNUS;   // 40 ns period

    always @(posedge protocolError) begin
        $display("Regression failed");
        $fatal(1, "SDRAM protocol monitor reported a violation");
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Sample and drive point 5 ns after the rising edge
    task automatic tick();
        @(posedge CAS_AGNUS);
        #5;
    endtask

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("ERR %0t %s", $time, msg);
            $display("Regression failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic waitCmd(input logic [3:0] cmd, input int limit, input string what);
        int n;
        n = 0;
        while (pinCmd != cmd) begin
            if (n == limit) fail({"Timed out waiting for ", what});
            tick();
            n++;
        end
    endtask

    task automatic waitRamTa(input int limit);
        int n;
        n = 0;
        while (!ramTa) begin
            if (n == limit) fail("Timed out waiting for ramTa");
            tick();
            n++;
        end
        nRamSpace = 1'b1;                  // CPU ends its cycle on the ack
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Init with a CPU read already waiting
    ////////////////////////////////////////////////////////////////////////////

    task automatic initSequence();
        logic [3:0] seen[$];
        int         at[$];
        int         idx;
        idx = 0;
        while (pinCmd != chipRamPkg::Activate) begin
            if (idx == 40) fail("SDRAM init never handed over to the CPU");
            tick();
            idx++;
            if (idx == 1) check(clkEn, "clkEn not raised on the first clock");
            if (pinCmd == chipRamPkg::ModeRegister) check(cma == `MODE_WORD, "mode word on cma");
            if (pinCmd != chipRamPkg::Nop && pinCmd != chipRamPkg::Activate) begin
                seen.push_back(pinCmd);
                at.push_back(idx);
            end
        end
        check(seen.size() == 4, "wrong number of init commands");
        check(seen[0] == chipRamPkg::Precharge && seen[1] == chipRamPkg::ModeRegister,
              "init starts with Precharge then ModeRegister");
        check(seen[2] == chipRamPkg::AutoRefresh && seen[3] == chipRamPkg::AutoRefresh,
              "init ends with two AutoRefresh");
        check(at[1] - at[0] == `INIT_MODE_STEP - `INIT_PRECHARGE_STEP, "ModeRegister step");
        check(at[2] - at[0] == `INIT_REFRESH_STEP_A - `INIT_PRECHARGE_STEP, "first refresh step");
        check(at[3] - at[0] == `INIT_REFRESH_STEP_B - `INIT_PRECHARGE_STEP, "second refresh step");
        check(idx - at[0] > `INIT_DONE_STEP - `INIT_PRECHARGE_STEP, "CPU served before init done");
        waitRamTa(8);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // CPU cycles as single longwords or four-beat bursts
    ////////////////////////////////////////////////////////////////////////////

    task automatic cpuCycle(input logic isWrite, input logic isBurst);
        logic [20:1] addr;
        logic [3:0]  colCmd;
        int          taFirst;
        int          taLast;
        int          preStep;
        addr    = 20'(nextRand() >> 7);
        colCmd  = isWrite ? chipRamPkg::Write : chipRamPkg::Read;
        // ramTa window and Precharge step per cycle type
        if (isWrite) begin
            taFirst = 1;
            taLast  = isBurst ? 4 : 1;
            preStep = isBurst ? 5 : 3;
        end else begin
            taFirst = 3;
            taLast  = isBurst ? 6 : 3;
            preStep = isBurst ? 7 : 3;
        end
        cpuAddr   = addr;
        cpuRnW    = !isWrite;
        tt        = isBurst ? 2'b01 : 2'b00;
        nRamSpace = 1'b0;
        tick();
        waitCmd(chipRamPkg::Activate, 30, "CPU Activate");
        check(cma == {1'b0, addr[19:10]}, "CPU row on cma");
        check(burstCycle == isBurst && !dmaCycle, "CPU cycle flags at Activate");
        for (int k = 1; k <= preStep; k++) begin
            tick();
            check(ramTa == (k >= taFirst && k <= taLast), "ramTa outside its window");
            check(dbDir == isWrite, "dbDir does not follow the direction");
            if (k == 2) begin
                check(pinCmd == colCmd, "CPU column command");
                check(cma == {2'b00, addr[20], addr[9:2]}, "CPU column on cma");
            end else if (k == preStep) begin
                check(pinCmd == chipRamPkg::Precharge && !burstCycle, "CPU Precharge");
            end else begin
                check(pinCmd == chipRamPkg::Nop && burstCycle == isBurst, "CPU Nop step");
            end
            if (k == 3) begin
                check(lastCol == {2'b00, addr[20], addr[9:2]}, "monitor saw a different column");
            end
            if (k == taLast) nRamSpace = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Agnus DMA word cycle
    ////////////////////////////////////////////////////////////////////////////

    task automatic dmaAccess(input logic isWrite, input int holdClocks);
        logic [9:0] row;
        logic [9:0] col;
        logic [3:0] colCmd;
        int         n;
        row    = 10'(nextRand() >> 12);
        col    = 10'(nextRand() >> 12);
        colCmd = isWrite ? chipRamPkg::Write : chipRamPkg::Read;
        nAwe  = !isWrite;
        dra   = row;                      // Row strobe first
        nRas0 = 1'b0;
        tick();
        dra   = col;
        nCasL = 1'b0;
        tick();
        waitCmd(chipRamPkg::Activate, 30, "DMA Activate");
        check(cma == {1'b0, row}, "DMA row on cma");
        check(!nDbEn && dmaCycle && dbDir == isWrite, "DMA buffer at Activate");
        for (int k = 1; k <= 3; k++) begin
            tick();
            if (k == 1) check(rowOpen && openRow == {1'b0, row}, "monitor saw a different row");
            if (k == 2) begin
                check(pinCmd == colCmd, "DMA column command");
                check(cma == {2'b00, col[9:1]}, "DMA column on cma");
                check(wordSel == col[0], "wordSel is not column bit 0");
            end
            if (k < 3) check(!nDbEn && dmaCycle, "buffer closed early in DMA");
        end
        check(pinCmd == chipRamPkg::Precharge, "DMA Precharge");
        check(lastCol == {2'b00, col[9:1]}, "monitor saw a different column");
        if (isWrite) check(nDbEn && !dmaCycle, "buffer still open after DMA write");
        repeat (holdClocks) begin
            check(!nDbEn && dmaCycle, "buffer closed while CAS held");
            tick();
        end
        nCasL = 1'b1;
        nRas0 = 1'b1;
        n = 0;
        while (!nDbEn) begin
            if (n == 4) fail("Buffer never closed after CAS release");
            tick();
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Refresh spacing and CAS blocking
    ////////////////////////////////////////////////////////////////////////////

    task automatic refreshSpacing();
        int          gap;
        logic [15:0] countBefore;
        tick();
        waitCmd(chipRamPkg::AutoRefresh, `REFRESH_INTERVAL + 20, "first AutoRefresh");
        repeat (2) begin
            tick();
            gap = 1;
            while (pinCmd != chipRamPkg::AutoRefresh) begin
                if (gap > `REFRESH_INTERVAL + 8) fail("AutoRefresh spacing too long");
                tick();
                gap++;
            end
        end
        tick();                           // Refresh running with its command already out
        countBefore = refreshCount;
        nAwe  = 1'b0;
        dra   = 10'(nextRand() >> 12);
        nRas0 = 1'b0;
        nCasL = 1'b0;
        repeat (`REFRESH_INTERVAL + 10) begin
            tick();
            check(pinCmd != chipRamPkg::AutoRefresh, "AutoRefresh while CAS low");
        end
        check(refreshCount == countBefore, "monitor counted a refresh under CAS");
        nCasL = 1'b1;
        nRas0 = 1'b1;
        tick();
        waitCmd(chipRamPkg::AutoRefresh, 10, "AutoRefresh after CAS release");
    endtask

    // DMA and CPU asked for on the same clock
    task automatic priorityOrder();
        logic [20:1] addr;
        addr      = 20'(nextRand() >> 7);
        cpuAddr   = addr;
        cpuRnW    = 1'b1;
        tt        = 2'b00;
        nRamSpace = 1'b0;
        nAwe      = 1'b0;
        dra       = 10'(nextRand() >> 12);
        nRas0     = 1'b0;
        tick();
        dra   = 10'(nextRand() >> 12);
        nCasL = 1'b0;
        tick();
        waitCmd(chipRamPkg::Activate, 30, "first Activate");
        check(dmaCycle, "CPU served before the DMA");
        repeat (3) tick();
        check(pinCmd == chipRamPkg::Precharge && !ramTa, "DMA end before CPU");
        nCasL = 1'b1;
        nRas0 = 1'b1;
        tick();
        waitCmd(chipRamPkg::Activate, 30, "CPU Activate after DMA");
        check(!dmaCycle && cma == {1'b0, addr[19:10]}, "CPU row after DMA");
        waitRamTa(8);
    endtask

    initial begin
        nRESET    = 1'b0;
        cpuRnW    = 1'b1;
        tt        = 2'b00;
        nRas0     = 1'b1;
        nRas1     = 1'b1;
        nCasL     = 1'b1;
        nCasU     = 1'b1;
        nAwe      = 1'b1;
        dra       = '0;
        cpuAddr   = 20'(nextRand() >> 7);
        nRamSpace = 1'b0;                 // CPU read pending through init
        repeat (5) @(posedge CAS_AGNUS);
        #5;
        check(pinCmd == chipRamPkg::Nop && !clkEn && !ramTa, "reset pins");
        check(nDbEn && !dmaCycle && !burstCycle, "reset bus controls");
        nRESET = 1'b1;
        initSequence();
        cpuCycle(1'b0, 1'b0);
        cpuCycle(1'b1, 1'b0);
        cpuCycle(1'b0, 1'b1);
        cpuCycle(1'b1, 1'b1);
        dmaAccess(1'b0, 5);
        dmaAccess(1'b1, 0);
        refreshSpacing();
        priorityOrder();
        repeat (4) tick();
        $display("Regression passed");
        $finish;
    end

endmodule

/* tb/sdramMonitor.sv */
// SDRAM pin protocol monitor
// Tracks the open row and refreshes, flags illegal command sequences

module sdramMonitor (
    input  logic        CAS_AGNUS,
    input  logic        nRESET,
    input  logic        nCs,
    input  logic        nRas,
    input  logic        nCas,
    input  logic        nWe,
    input  logic        clkEn,
    input  logic [10:0] cma,
    output logic        rowOpen,
    output logic [10:0] openRow,        // Row of the last Activate
    output logic [10:0] lastCol,
    output logic [15:0] refreshCount,
    output logic        protocolError
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0] cmd;
    logic [7:0] sinceActivate;   // Clocks since the last Activate, saturating

    assign cmd = {nCs, nRas, nCas, nWe};

    task automatic flag(input string msg);
        $display("SDRAM protocol violation at %0t: %s", $time, msg);
        protocolError <= 1'b1;
    endtask

    // Pins change on the clock edge, so the old values are read here
    always @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            rowOpen       <= 1'b0;
            openRow       <= '0;
            lastCol       <= '0;
            refreshCount  <= '0;
            protocolError <= 1'b0;
            sinceActivate <= '0;
        end else begin
            if (sinceActivate != 8'hff) sinceActivate <= sinceActivate + 8'd1;
            if (!clkEn && cmd != chipRamPkg::Nop) flag("command issued while clkEn low");
            case (cmd)
                chipRamPkg::Nop: ;
                chipRamPkg::Activate: begin
                    if (rowOpen) flag("Activate while a row is open");
                    rowOpen       <= 1'b1;
                    openRow       <= cma;
                    sinceActivate <= '0;
                end
                chipRamPkg::Read,
                chipRamPkg::Write: begin
                    if (!rowOpen) flag("column command with no open row");
                    if (sinceActivate < 8'd1) flag("column command too soon after Activate");
                    lastCol <= cma;
                end
                chipRamPkg::Precharge: begin
                    if (!cma[10]) flag("Precharge without A10 set");
                    rowOpen <= 1'b0;             // All banks closed
                end
                chipRamPkg::AutoRefresh: begin
                    if (rowOpen) flag("AutoRefresh with a row open");
                    refreshCount <= refreshCount + 16'd1;
                end
                chipRamPkg::ModeRegister: begin
                    if (rowOpen) flag("ModeRegister with a row open");
                end
                default: flag("unknown SDRAM command code");
            endcase
        end
    end

endmodule

/* source/chipRamTop.sv */
// Chip RAM controller top
// SDRAM behind the Agnus chip bus, CPU and DMA cycles with refresh

module chipRamTop (
    input  logic        CAS_AGNUS,
    input  logic        nRESET,
    // CPU side
    input  logic        nRamSpace,
    input  logic [20:1] cpuAddr,
    input  logic        cpuRnW,
    input  logic [1:0]  tt,
    // Agnus side
    input  logic        nRas0,
    input  logic        nRas1,
    input  logic        nCasL,
    input  logic        nCasU,
    input  logic        nAwe,
    input  logic [9:0]  dra,
    // SDRAM
    output logic        nCs,
    output logic        nRas,
    output logic        nCas,
    output logic        nWe,
    output logic        clkEn,
    output logic [10:0] cma,
    // Bus control
    output logic        ramTa,
    output logic        nDbEn,
    output logic        dbDir,
    output logic        dmaCycle,
    output logic        burstCycle,
    output logic        wordSel
);

    logic [9:0]           dmaRow;
    logic [9:0]           dmaCol;
    logic                 dmaReady;
    logic                 rasPending;
    logic                 casActive;
    logic                 refreshDue;
    logic                 refreshAck;
    logic                 writeCycle;
    logic                 dbHold;
    chipRamPkg::sdramCmd  nextCmd;
    chipRamPkg::cycleKind kind;

    agnusCapture uCapture (
        .CAS_AGNUS(CAS_AGNUS), .nRESET(nRESET),
        .nRas0(nRas0), .nRas1(nRas1), .nCasL(nCasL), .nCasU(nCasU),
        .dra(dra), .dmaCycle(dmaCycle),
        .dmaRow(dmaRow), .dmaCol(dmaCol), .dmaReady(dmaReady),
        .rasPending(rasPending), .casActive(casActive)
    );

    refreshTimer uRefresh (
        .CAS_AGNUS(CAS_AGNUS), .nRESET(nRESET),
        .refreshAck(refreshAck), .refreshDue(refreshDue)
    );

    cycleSequencer uSeq (
        .CAS_AGNUS(CAS_AGNUS), .nRESET(nRESET),
        .nRamSpace(nRamSpace), .cpuRnW(cpuRnW), .tt(tt), .nAwe(nAwe),
        .dmaReady(dmaReady), .rasPending(rasPending), .casActive(casActive),
        .refreshDue(refreshDue),
        .nextCmd(nextCmd), .kind(kind), .ramTa(ramTa), .clkEn(clkEn),
        .burstCycle(burstCycle), .writeCycle(writeCycle), .dmaCycle(dmaCycle),
        .refreshAck(refreshAck), .dbHold(dbHold)
    );

    // A1 only picks the word on the CPU bus, SDRAM is longword wide
    sdramCmdOut uPins (
        .CAS_AGNUS(CAS_AGNUS), .nRESET(nRESET),
        .nextCmd(nextCmd), .kind(kind), .cpuAddr(cpuAddr[20:2]),
        .dmaRow(dmaRow), .dmaCol(dmaCol), .writeCycle(writeCycle), .dbHold(dbHold),
        .nCs(nCs), .nRas(nRas), .nCas(nCas), .nWe(nWe), .cma(cma),
        .nDbEn(nDbEn), .dbDir(dbDir), .wordSel(wordSel)
    );

endmodule

/* source/sdramCmdOut.sv */
// SDRAM pin driver
// Registers the command, muxes the row/column address and data buffer controls

`include "chipRam_cfg.svh"

module sdramCmdOut (
    input  logic                 CAS_AGNUS,
    input  logic                 nRESET,
    input  chipRamPkg::sdramCmd  nextCmd,
    input  chipRamPkg::cycleKind kind,
    input  logic [20:2]          cpuAddr,    // Longword address, A1 not used by SDRAM
    input  logic [9:0]           dmaRow,
    input  logic [9:0]           dmaCol,
    input  logic                 writeCycle,
    input  logic                 dbHold,
    output logic                 nCs,
    output logic                 nRas,
    output logic                 nCas,
    output logic                 nWe,
    output logic [10:0]          cma,
    output logic                 nDbEn,
    output logic                 dbDir,
    output logic                 wordSel
);

    chipRamPkg::sdramCmd cmdQ;
    logic                isDma;

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) cmdQ <= chipRamPkg::Nop;
        else         cmdQ <= nextCmd;
    end

    assign {nCs, nRas, nCas, nWe} = cmdQ;
    assign isDma = (kind == chipRamPkg::Dma);

    ////////////////////////////////////////////////////////////////////////////
    // Address mux, row is A19..A10, column is A20 then A9..A2
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (cmdQ)
            chipRamPkg::Precharge:    cma = 11'h400;          // All banks
            chipRamPkg::ModeRegister: cma = `MODE_WORD;
            chipRamPkg::Activate:     cma = isDma ? {1'b0, dmaRow} : {1'b0, cpuAddr[19:10]};
            chipRamPkg::Read,
            chipRamPkg::Write: begin
                if (isDma) cma = {2'b00, dmaCol[9:1]};        // Agnus word pairs share a column
                else       cma = {2'b00, cpuAddr[20], cpuAddr[9:2]};
            end
            default:                  cma = '0;
        endcase
    end

    // Data buffer between chip bus and SDRAM, open only for DMA
    assign nDbEn   = !(isDma || dbHold);
    assign dbDir   = writeCycle;      // High drives toward the SDRAM
    assign wordSel = dmaCol[0];       // Upper or lower word of the longword

    // Idle pins carry a clean address bus
    assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        $past(nextCmd) == chipRamPkg::Nop |-> cma == '0)
        else $error("cma not zero on Nop");

endmodule

/* source/cycleSequencer.sv */
// Chip RAM cycle sequencer
// Runs SDRAM init, then arbitrates refresh, Agnus DMA and CPU cycles

`include "chipRam_cfg.svh"

module cycleSequencer (
    input  logic                 CAS_AGNUS,
    input  logic                 nRESET,
    input  logic                 nRamSpace,
    input  logic                 cpuRnW,
    input  logic [1:0]           tt,
    input  logic                 nAwe,
    input  logic                 dmaReady,
    input  logic                 rasPending,
    input  logic                 casActive,
    input  logic                 refreshDue,
    output chipRamPkg::sdramCmd  nextCmd,     // Registered onto the pins next clock
    output chipRamPkg::cycleKind kind,
    output logic                 ramTa,
    output logic                 clkEn,
    output logic                 burstCycle,
    output logic                 writeCycle,
    output logic                 dmaCycle,
    output logic                 refreshAck,
    output logic                 dbHold       // DMA read waiting for Agnus CAS release
);

    logic [3:0] step;        // Init step, then step within a cycle
    logic       initDone;
    logic       idle;
    logic       startRefresh;
    logic       startDma;
    logic       startCpu;
    logic [3:0] lastStep;    // Step that issues Precharge
    logic [3:0] taFirst;
    logic [3:0] taLast;

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration, refresh over DMA over CPU
    ////////////////////////////////////////////////////////////////////////////

    assign idle         = initDone && (step == 4'd0) && !dbHold;
    assign startRefresh = idle && refreshDue && !casActive;   // Never under an Agnus CAS
    assign startDma     = idle && !startRefresh && dmaReady;
    // CPU waits while one RAS is low, and for the clock that still shows ramTa
    assign startCpu     = idle && !startRefresh && !dmaReady && !nRamSpace
                          && !rasPending && !ramTa;

    assign refreshAck = startRefresh;
    assign dmaCycle   = (kind == chipRamPkg::Dma) || dbHold;

    // Cycle length and ramTa window
    assign lastStep = !burstCycle ? 4'd3 : (writeCycle ? 4'd5 : 4'd7);
    assign taFirst  = writeCycle ? 4'd1 : 4'd3;   // Writes ack early, reads after CL
    assign taLast   = taFirst + (burstCycle ? 4'd3 : 4'd0);

    ////////////////////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextCmd = chipRamPkg::Nop;
        if (!initDone) begin
            case (step)
                4'(`INIT_PRECHARGE_STEP): nextCmd = chipRamPkg::Precharge;
                4'(`INIT_MODE_STEP):      nextCmd = chipRamPkg::ModeRegister;
                4'(`INIT_REFRESH_STEP_A),
                4'(`INIT_REFRESH_STEP_B): nextCmd = chipRamPkg::AutoRefresh;
                default:                  nextCmd = chipRamPkg::Nop;
            endcase
        end else if (startRefresh) begin
            nextCmd = chipRamPkg::AutoRefresh;
        end else if (startDma || startCpu) begin
            nextCmd = chipRamPkg::Activate;
        end else if (kind == chipRamPkg::Cpu || kind == chipRamPkg::Dma) begin
            if (step == 4'd2) begin
                nextCmd = writeCycle ? chipRamPkg::Write : chipRamPkg::Read;
            end else if (step == lastStep) begin
                nextCmd = chipRamPkg::Precharge;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step counter and cycle state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            step       <= '0;
            initDone   <= 1'b0;
            kind       <= chipRamPkg::Idle;
            ramTa      <= 1'b0;
            clkEn      <= 1'b0;
            burstCycle <= 1'b0;
            writeCycle <= 1'b0;
            dbHold     <= 1'b0;
        end else begin
            ramTa <= 1'b0;                        // Default, one-clock acks
            if (!initDone) begin
                clkEn <= 1'b1;                    // Up on the first clock, stays up
                if (step == 4'(`INIT_DONE_STEP)) begin
                    initDone <= 1'b1;
                    step     <= '0;
                end else begin
                    step <= step + 4'd1;
                end
            end else if (startRefresh) begin
                kind <= chipRamPkg::Refresh;
                step <= 4'd1;
            end else if (startDma) begin
                kind       <= chipRamPkg::Dma;
                step       <= 4'd1;
                writeCycle <= !nAwe;
                burstCycle <= 1'b0;
            end else if (startCpu) begin
                kind       <= chipRamPkg::Cpu;
                step       <= 4'd1;
                writeCycle <= !cpuRnW;
                burstCycle <= (tt == 2'b01);      // Line transfer
            end else if (dbHold) begin
                if (!casActive) dbHold <= 1'b0;   // Agnus done reading
            end else if (kind == chipRamPkg::Refresh) begin
                if (step == 4'd3) begin           // tRC covered by three Nops
                    step <= '0;
                    kind <= chipRamPkg::Idle;
                end else begin
                    step <= step + 4'd1;
                end
            end else if (kind != chipRamPkg::Idle) begin
                ramTa <= (kind == chipRamPkg::Cpu) && (step >= taFirst) && (step <= taLast);
                if (step == lastStep) begin
                    step       <= '0;
                    kind       <= chipRamPkg::Idle;
                    burstCycle <= 1'b0;
                    // DMA read keeps the buffer open while CAS is still low
                    dbHold     <= (kind == chipRamPkg::Dma) && !writeCycle && casActive;
                end else begin
                    step <= step + 4'd1;
                end
            end
        end
    end

    // Column commands only into a row opened by this cycle
    assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        nextCmd inside {chipRamPkg::Read, chipRamPkg::Write}
        |-> $past(nextCmd, 2) == chipRamPkg::Activate)
        else $error("Read or Write without Activate");

endmodule

/* source/refreshTimer.sv */
// SDRAM refresh timer
// Counts clocks since the last auto refresh and raises refreshDue

`include "chipRam_cfg.svh"

module refreshTimer (
    input  logic CAS_AGNUS,
    input  logic nRESET,
    input  logic refreshAck,   // One clock, AutoRefresh going out
    output logic refreshDue
);

    logic [5:0] count;

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            count      <= '0;
            refreshDue <= 1'b0;
        end else if (refreshAck) begin
            count      <= '0;
            refreshDue <= 1'b0;
        end else begin
            if (count != 6'h3f) count <= count + 6'd1;   // Saturate, never wrap
            if (count >= 6'(`REFRESH_INTERVAL)) refreshDue <= 1'b1;
        end
    end

    // Sequencer must only refresh when asked
    assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        refreshAck |-> refreshDue)
        else $error("refreshAck without refreshDue");

endmodule

/* source/agnusCapture.sv */
// Agnus DMA address capture
// Latches row and column off the multiplexed dra bus and flags a pending DMA

module agnusCapture (
    input  logic       CAS_AGNUS,
    input  logic       nRESET,
    input  logic       nRas0,
    input  logic       nRas1,
    input  logic       nCasL,
    input  logic       nCasU,
    input  logic [9:0] dra,
    input  logic       dmaCycle,    // Sequencer is serving the DMA
    output logic [9:0] dmaRow,
    output logic [9:0] dmaCol,
    output logic       dmaReady,
    output logic       rasPending,
    output logic       casActive
);

    logic rasLow;
    logic rasLowQ;   // Strobe levels seen at the previous clock
    logic casLowQ;

    assign rasLow     = !nRas0 || !nRas1;
    assign casActive  = !nCasL || !nCasU;
    assign rasPending = nRas0 ^ nRas1;   // Both low is an Agnus refresh, not DMA

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            rasLowQ  <= 1'b0;
            casLowQ  <= 1'b0;
            dmaReady <= 1'b0;
        end else begin
            rasLowQ <= rasLow;
            casLowQ <= casActive;
            if (casActive && !casLowQ) begin
                dmaReady <= 1'b1;         // New column strobe wins over the clear
            end else if (dmaCycle) begin
                dmaReady <= 1'b0;
            end
        end
    end

    // Address latches, first clock of each strobe
    always_ff @(posedge CAS_AGNUS) begin
        if (rasLow && !rasLowQ) dmaRow <= dra;
        if (casActive && !casLowQ) dmaCol <= dra;
    end

    // A pending DMA always carries the column sampled on the same edge
    assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        $rose(dmaReady) |-> dmaCol == $past(dra))
        else $error("dmaReady rose without a column capture");

endmodule

/* source/chipRamPkg.sv */
// Chip RAM controller shared types
// SDRAM command encodings and the kinds of memory cycle

package chipRamPkg;

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM commands, bits are {nCs, nRas, nCas, nWe}
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        Nop          = 4'b1111,  // Deselect, nothing issued
        Precharge    = 4'b0010,  // A10 high closes all banks
        Activate     = 4'b0011,  // Open a row
        Read         = 4'b0101,
        Write        = 4'b0100,
        AutoRefresh  = 4'b0001,
        ModeRegister = 4'b0000   // Load mode word from cma
    } sdramCmd;

    // Which cycle currently owns the SDRAM
    typedef enum logic [1:0] {
        Idle    = 2'd0,
        Refresh = 2'd1,
        Cpu     = 2'd2,  // CPU longword or burst
        Dma     = 2'd3   // Agnus word access
    } cycleKind;

endpackage

/* source/chipRam_cfg.svh */
// Chip RAM controller configuration
// Refresh spacing, SDRAM init schedule and mode register word

`ifndef CHIPRAM_CFG_SVH
`define CHIPRAM_CFG_SVH

// Clocks between refresh requests, fits the 6-bit timer
`define REFRESH_INTERVAL 54

// Init schedule, step 0 is the first clock after reset
`define INIT_PRECHARGE_STEP 1
`define INIT_MODE_STEP 3
`define INIT_REFRESH_STEP_A 4
`define INIT_REFRESH_STEP_B 9
`define INIT_DONE_STEP 13

// Burst length 4, sequential, CAS latency 2
`define MODE_WORD 11'h022

`endif
